/* verilog/rename_pkg.sv */
package rename_pkg;

    localparam int XLEN       = 32;
    localparam int ARCH_REG_W = 5;
    localparam int PHYS_REG_W = 6;
    localparam int ROB_IDX_W  = 5;

    // RV32 major opcodes
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;
    localparam logic [6:0] OP_BR    = 7'b1100011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_lui,
        alu_auipc,
        alu_jal,
        alu_jalr,
        alu_branch,
        alu_mult,
        alu_div
    } aluop_e;

    // Values follow the branch funct3 field
    typedef enum logic [2:0] {
        eq  = 3'b000,
        ne  = 3'b001,
        lt  = 3'b100,
        ge  = 3'b101,
        ltu = 3'b110,
        geu = 3'b111
    } cmpop_e;

    typedef enum logic [2:0] {
        cls_alu,
        cls_mult,
        cls_mem,
        cls_branch,
        cls_illegal
    } disp_class_e;

    typedef enum logic [2:0] {
        fmt_none,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_e;

endpackage

/* verilog/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import rename_pkg::*;

    disp_class_e disp_class;   // Which station gets the instruction
    aluop_e      aluop;
    cmpop_e      cmpop;
    logic [1:0]  mult_type;    // Signedness select for the multiply unit
    logic        is_rem;
    logic        use_imm;      // Second operand is the immediate
    logic        is_load;
    logic        is_store;
    logic        read_rs1;
    logic        read_rs2;
    logic        writes_rd;

    modport dec (
        output disp_class, aluop, cmpop, mult_type, is_rem,
               use_imm, is_load, is_store, read_rs1, read_rs2, writes_rd
    );

    modport ren (
        input  disp_class, aluop, cmpop, mult_type, is_rem,
               use_imm, is_load, is_store, read_rs1, read_rs2, writes_rd
    );
endinterface

/* verilog/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  rename_pkg::imm_fmt_e        fmt,
    input  logic [rename_pkg::XLEN-1:0] inst,
    output logic [rename_pkg::XLEN-1:0] imm
);
    import rename_pkg::*;

    logic sign;

    assign sign = inst[31];   // Every format takes its sign from bit 31

    always_comb begin
        case (fmt)
            fmt_i: begin
                imm = {{21{sign}}, inst[30:20]};
            end
            fmt_s: begin
                imm = {{21{sign}}, inst[30:25], inst[11:7]};
            end
            fmt_b: begin
                imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            fmt_u: begin
                imm = {inst[31:12], 12'h000};   // Upper 20 bits, no extension
            end
            fmt_j: begin
                imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;   // R-type and illegal
            end
        endcase
    end

endmodule

/* verilog/op_decode.sv */
`timescale 1ns/1ps

module op_decode (
    input  logic [rename_pkg::XLEN-1:0] inst,
    output rename_pkg::imm_fmt_e        fmt,
    decode_if.dec                       dec
);
    import rename_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Base integer op, shared by OP and OP-IMM
    // SUB exists only in the register form
    function automatic aluop_e base_aluop(input logic [2:0] f3, input logic alt,
                                          input logic sub_ok);
        aluop_e op;
        case (f3)
            3'b000:  op = (alt && sub_ok) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        fmt            = fmt_none;
        dec.disp_class = cls_illegal;   // Anything unmatched is discarded
        dec.aluop      = alu_add;
        dec.cmpop      = eq;
        dec.mult_type  = 2'b00;
        dec.is_rem     = 1'b0;
        dec.use_imm    = 1'b0;
        dec.is_load    = 1'b0;
        dec.is_store   = 1'b0;
        dec.read_rs1   = 1'b0;
        dec.read_rs2   = 1'b0;
        dec.writes_rd  = 1'b0;

        case (opcode)
            OP_LUI, OP_AUIPC: begin
                dec.disp_class = cls_alu;
                dec.aluop      = (opcode == OP_LUI) ? alu_lui : alu_auipc;
                dec.use_imm    = 1'b1;
                dec.writes_rd  = 1'b1;
                fmt            = fmt_u;
            end
            OP_JAL: begin
                dec.disp_class = cls_branch;
                dec.aluop      = alu_jal;
                dec.use_imm    = 1'b1;
                dec.writes_rd  = 1'b1;   // Link register
                fmt            = fmt_j;
            end
            OP_JALR: begin
                dec.disp_class = cls_branch;
                dec.aluop      = alu_jalr;
                dec.use_imm    = 1'b1;
                dec.read_rs1   = 1'b1;
                dec.writes_rd  = 1'b1;
                fmt            = fmt_i;
            end
            OP_BR: begin
                // funct3 010 and 011 are not branches
                if (funct3[2:1] != 2'b01) begin
                    dec.disp_class = cls_branch;
                    dec.aluop      = alu_branch;
                    dec.cmpop      = cmpop_e'(funct3);
                    dec.read_rs1   = 1'b1;
                    dec.read_rs2   = 1'b1;
                    fmt            = fmt_b;
                end
            end
            OP_LOAD: begin
                dec.disp_class = cls_mem;
                dec.is_load    = 1'b1;
                dec.use_imm    = 1'b1;
                dec.read_rs1   = 1'b1;
                dec.writes_rd  = 1'b1;
                fmt            = fmt_i;
            end
            OP_STORE: begin
                dec.disp_class = cls_mem;
                dec.is_store   = 1'b1;
                dec.use_imm    = 1'b1;
                dec.read_rs1   = 1'b1;   // Base address
                dec.read_rs2   = 1'b1;   // Store data
                fmt            = fmt_s;
            end
            OP_IMM: begin
                dec.disp_class = cls_alu;
                dec.aluop      = base_aluop(funct3, funct7[5], 1'b0);
                dec.use_imm    = 1'b1;
                dec.read_rs1   = 1'b1;
                dec.writes_rd  = 1'b1;
                fmt            = fmt_i;
            end
            OP_REG: begin
                dec.read_rs1  = 1'b1;
                dec.read_rs2  = 1'b1;
                dec.writes_rd = 1'b1;
                if (funct7[0]) begin
                    // M extension, funct3[2] splits multiply from divide
                    dec.disp_class = cls_mult;
                    dec.aluop      = funct3[2] ? alu_div : alu_mult;
                    dec.mult_type  = funct3[2] ? {funct3[0], 1'b1} : funct3[1:0];
                    dec.is_rem     = funct3[2] & funct3[1];
                end else begin
                    dec.disp_class = cls_alu;
                    dec.aluop      = base_aluop(funct3, funct7[5], 1'b1);
                end
            end
            default: ;
        endcase
    end

endmodule

/* verilog/rename_dispatch.sv */
`timescale 1ns/1ps

module rename_dispatch (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              iq_empty,
    input  logic                              rs_open,
    input  logic                              mult_rs_open,
    input  logic                              lsq_full,
    input  logic                              rob_full,
    input  logic                              freelist_empty,
    input  logic [rename_pkg::XLEN-1:0]       inst,
    input  logic [rename_pkg::XLEN-1:0]       iq_pc,
    input  logic [rename_pkg::XLEN-1:0]       imm,
    input  logic [rename_pkg::PHYS_REG_W-1:0] pd,
    input  logic [rename_pkg::ROB_IDX_W-1:0]  rob_index,
    decode_if.ren                             dec,
    output logic                              iq_dequeue,
    output logic                              freelist_dequeue,
    output logic                              rs_dispatch,
    output logic                              mult_rs_dispatch,
    output logic                              lsq_dispatch,
    output logic                              br_dispatch,
    output logic [rename_pkg::XLEN-1:0]       out_pc,
    output logic [rename_pkg::XLEN-1:0]       out_imm,
    output logic [rename_pkg::ARCH_REG_W-1:0] out_rd,
    output logic [rename_pkg::ARCH_REG_W-1:0] out_rs1,
    output logic [rename_pkg::ARCH_REG_W-1:0] out_rs2,
    output logic [rename_pkg::PHYS_REG_W-1:0] out_pd,
    output logic [rename_pkg::ROB_IDX_W-1:0]  out_rob_entry,
    output rename_pkg::aluop_e                out_aluop,
    output rename_pkg::cmpop_e                out_cmpop,
    output logic [1:0]                        out_mult_type,
    output logic                              out_is_rem,
    output logic                              out_use_imm,
    output logic                              out_is_load,
    output logic                              out_is_store,
    output logic [2:0]                        out_funct3
);
    import rename_pkg::*;

    logic [ARCH_REG_W-1:0] rd;
    logic                  need_pd;
    logic                  target_open;
    logic                  take;

    assign rd      = inst[11:7];
    assign need_pd = dec.writes_rd && (rd != '0);   // x0 never gets a new tag

    always_comb begin
        case (dec.disp_class)
            cls_alu:              target_open = rs_open;
            cls_mult:             target_open = mult_rs_open;
            cls_mem, cls_branch:  target_open = !lsq_full;   // Branch unit shares the LSQ gate
            default:              target_open = 1'b1;        // Illegal goes nowhere
        endcase
    end

    assign take = !rst && !iq_empty && !rob_full && target_open
                  && !(need_pd && freelist_empty);

    assign iq_dequeue       = take;
    assign freelist_dequeue = take && need_pd;

    always_ff @(posedge clk) begin
        if (rst) begin
            rs_dispatch      <= 1'b0;
            mult_rs_dispatch <= 1'b0;
            lsq_dispatch     <= 1'b0;
            br_dispatch      <= 1'b0;
        end else begin
            rs_dispatch      <= take && (dec.disp_class == cls_alu);
            mult_rs_dispatch <= take && (dec.disp_class == cls_mult);
            lsq_dispatch     <= take && (dec.disp_class == cls_mem);
            br_dispatch      <= take && (dec.disp_class == cls_branch);
        end
    end

    // Renamed bundle, held until the next take
    always_ff @(posedge clk) begin
        if (take) begin
            out_pc        <= iq_pc;
            out_imm       <= imm;
            out_rd        <= dec.writes_rd ? rd : '0;
            out_rs1       <= dec.read_rs1 ? inst[19:15] : '0;
            out_rs2       <= dec.read_rs2 ? inst[24:20] : '0;
            out_pd        <= need_pd ? pd : '0;
            out_rob_entry <= rob_index;
            out_aluop     <= dec.aluop;
            out_cmpop     <= dec.cmpop;
            out_mult_type <= dec.mult_type;
            out_is_rem    <= dec.is_rem;
            out_use_imm   <= dec.use_imm;
            out_is_load   <= dec.is_load;
            out_is_store  <= dec.is_store;
            out_funct3    <= inst[14:12];   // Access width for the LSQ
        end
    end

endmodule

/* verilog/decode_rename.sv */
`timescale 1ns/1ps

module decode_rename (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              iq_empty,
    input  logic [rename_pkg::XLEN-1:0]       iq_inst,
    input  logic [rename_pkg::XLEN-1:0]       iq_pc,
    output logic                              iq_dequeue,
    input  logic                              rs_open,
    input  logic                              mult_rs_open,
    input  logic                              lsq_full,
    input  logic                              rob_full,
    input  logic                              freelist_empty,
    input  logic [rename_pkg::PHYS_REG_W-1:0] pd,
    input  logic [rename_pkg::ROB_IDX_W-1:0]  rob_index,
    output logic                              freelist_dequeue,
    output logic                              rs_dispatch,
    output logic                              mult_rs_dispatch,
    output logic                              lsq_dispatch,
    output logic                              br_dispatch,
    output logic [rename_pkg::XLEN-1:0]       out_pc,
    output logic [rename_pkg::XLEN-1:0]       out_imm,
    output logic [rename_pkg::ARCH_REG_W-1:0] out_rd,
    output logic [rename_pkg::ARCH_REG_W-1:0] out_rs1,
    output logic [rename_pkg::ARCH_REG_W-1:0] out_rs2,
    output logic [rename_pkg::PHYS_REG_W-1:0] out_pd,
    output logic [rename_pkg::ROB_IDX_W-1:0]  out_rob_entry,
    output rename_pkg::aluop_e                out_aluop,
    output rename_pkg::cmpop_e                out_cmpop,
    output logic [1:0]                        out_mult_type,
    output logic                              out_is_rem,
    output logic                              out_use_imm,
    output logic                              out_is_load,
    output logic                              out_is_store,
    output logic [2:0]                        out_funct3
);
    import rename_pkg::*;

    imm_fmt_e        imm_fmt;
    logic [XLEN-1:0] imm;

    decode_if dec_bus ();   // Control bundle from decoder to rename

    op_decode u_op_decode (
        .inst (iq_inst),
        .fmt  (imm_fmt),
        .dec  (dec_bus.dec)
    );

    imm_gen u_imm_gen (
        .fmt  (imm_fmt),
        .inst (iq_inst),
        .imm  (imm)
    );

    rename_dispatch u_rename_dispatch (
        .clk              (clk),
        .rst              (rst),
        .iq_empty         (iq_empty),
        .rs_open          (rs_open),
        .mult_rs_open     (mult_rs_open),
        .lsq_full         (lsq_full),
        .rob_full         (rob_full),
        .freelist_empty   (freelist_empty),
        .inst             (iq_inst),
        .iq_pc            (iq_pc),
        .imm              (imm),
        .pd               (pd),
        .rob_index        (rob_index),
        .dec              (dec_bus.ren),
        .iq_dequeue       (iq_dequeue),
        .freelist_dequeue (freelist_dequeue),
        .rs_dispatch      (rs_dispatch),
        .mult_rs_dispatch (mult_rs_dispatch),
        .lsq_dispatch     (lsq_dispatch),
        .br_dispatch      (br_dispatch),
        .out_pc           (out_pc),
        .out_imm          (out_imm),
        .out_rd           (out_rd),
        .out_rs1          (out_rs1),
        .out_rs2          (out_rs2),
        .out_pd           (out_pd),
        .out_rob_entry    (out_rob_entry),
        .out_aluop        (out_aluop),
        .out_cmpop        (out_cmpop),
        .out_mult_type    (out_mult_type),
        .out_is_rem       (out_is_rem),
        .out_use_imm      (out_use_imm),
        .out_is_load      (out_is_load),
        .out_is_store     (out_is_store),
        .out_funct3       (out_funct3)
    );

endmodule

/* tb/decode_rename_assert.sv */
`timescale 1ns/1ps

module decode_rename_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    iq_dequeue,
    input logic                    freelist_dequeue,
    input logic                    rs_dispatch,
    input logic                    mult_rs_dispatch,
    input logic                    lsq_dispatch,
    input logic                    br_dispatch,
    input rename_pkg::disp_class_e cls
);
    import rename_pkg::*;

    logic [3:0] strobes;
    int         fail_count = 0;   // Read by the testbench at the end of the run

    assign strobes = {rs_dispatch, mult_rs_dispatch, lsq_dispatch, br_dispatch};

    function automatic logic [3:0] strobe_for(input disp_class_e c);
        case (c)
            cls_alu:    return 4'b1000;
            cls_mult:   return 4'b0100;
            cls_mem:    return 4'b0010;
            cls_branch: return 4'b0001;
            default:    return 4'b0000;   // Illegal is dropped
        endcase
    endfunction

    a_one_strobe: assert property (@(posedge clk) disable iff (rst) $onehot0(strobes))
        else begin
            $error("More than one dispatch strobe is high");
            fail_count++;
        end

    a_fl_with_iq: assert property (@(posedge clk) disable iff (rst)
        freelist_dequeue |-> iq_dequeue)
        else begin
            $error("freelist_dequeue raised without iq_dequeue");
            fail_count++;
        end

    a_class_strobe: assert property (@(posedge clk) disable iff (rst)
        iq_dequeue |=> strobes == strobe_for($past(cls)))
        else begin
            $error("Dispatch strobe does not match the class of the taken instruction");
            fail_count++;
        end

endmodule

bind decode_rename decode_rename_assert u_dispatch_assert (
    .clk              (clk),
    .rst              (rst),
    .iq_dequeue       (iq_dequeue),
    .freelist_dequeue (freelist_dequeue),
    .rs_dispatch      (rs_dispatch),
    .mult_rs_dispatch (mult_rs_dispatch),
    .lsq_dispatch     (lsq_dispatch),
    .br_dispatch      (br_dispatch),
    .cls              (dec_bus.disp_class)
);

/* tb/tb_decode_rename.sv */
`timescale 1ns/1ps

module tb_decode_rename;
    import rename_pkg::*;

    localparam logic [31:0] SEED           = 32'h1e34a488;
    localparam int          STROBE_TIMEOUT = 4;

    // Condition bits {rd_x0, rs_open, mult_rs_open, lsq_full, rob_full, freelist_empty}
    localparam logic [5:0] OPEN     = 6'b011000;
    localparam logic [5:0] NO_RS    = 6'b010000;   // Toggles are applied with xor
    localparam logic [5:0] NO_MULT  = 6'b001000;
    localparam logic [5:0] LSQ_BUSY = 6'b000100;
    localparam logic [5:0] ROB_BUSY = 6'b000010;
    localparam logic [5:0] FL_DRY   = 6'b000001;
    localparam logic [5:0] RD_X0    = 6'b100000;

    typedef struct {
        string       name;
        logic [31:0] tmpl;    // Opcode, funct3, funct7, all else zero
        imm_fmt_e    fmt;     // fmt_none for R-type and illegal
        logic [5:0]  cond;
        logic        take;
        disp_class_e cls;
        aluop_e      aluop;
        cmpop_e      cmpop;
        logic [1:0]  mtype;
        logic        is_rem;
    } entry_t;

    entry_t      table_q[$];
    logic [31:0] lfsr;
    int          errors;

    logic                  clk;
    logic                  rst;
    logic                  iq_empty;
    logic [XLEN-1:0]       iq_inst;
    logic [XLEN-1:0]       iq_pc;
    logic                  iq_dequeue;
    logic                  rs_open;
    logic                  mult_rs_open;
    logic                  lsq_full;
    logic                  rob_full;
    logic                  freelist_empty;
    logic [PHYS_REG_W-1:0] pd;
    logic [ROB_IDX_W-1:0]  rob_index;
    logic                  freelist_dequeue;
    logic                  rs_dispatch;
    logic                  mult_rs_dispatch;
    logic                  lsq_dispatch;
    logic                  br_dispatch;
    logic [XLEN-1:0]       out_pc;
    logic [XLEN-1:0]       out_imm;
    logic [ARCH_REG_W-1:0] out_rd;
    logic [ARCH_REG_W-1:0] out_rs1;
    logic [ARCH_REG_W-1:0] out_rs2;
    logic [PHYS_REG_W-1:0] out_pd;
    logic [ROB_IDX_W-1:0]  out_rob_entry;
    aluop_e                out_aluop;
    cmpop_e                out_cmpop;
    logic [1:0]            out_mult_type;
    logic                  out_is_rem;
    logic                  out_use_imm;
    logic                  out_is_load;
    logic                  out_is_store;
    logic [2:0]            out_funct3;
    logic [3:0]            strobes;

    assign strobes = {rs_dispatch, mult_rs_dispatch, lsq_dispatch, br_dispatch};

    decode_rename u_dut (.*);

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Immediate layouts of the RV32 base formats
    function automatic logic [31:0] expect_imm(input imm_fmt_e f, input logic [31:0] i);
        case (f)
            fmt_i:   return {{20{i[31]}}, i[31:20]};
            fmt_s:   return {{20{i[31]}}, i[31:25], i[11:7]};
            fmt_b:   return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            fmt_u:   return {i[31:12], 12'b0};
            fmt_j:   return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [3:0] class_strobes(input disp_class_e c);
        case (c)
            cls_alu:    return 4'b1000;
            cls_mult:   return 4'b0100;
            cls_mem:    return 4'b0010;
            cls_branch: return 4'b0001;
            default:    return 4'b0000;
        endcase
    endfunction

    task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic add(input string name, input logic [31:0] tmpl, input imm_fmt_e fmt,
                       input logic [5:0] cond, input logic take, input disp_class_e cls,
                       input aluop_e aluop, input cmpop_e cmpop = eq,
                       input logic [1:0] mtype = 2'd0, input logic is_rem = 1'b0);
        entry_t e;
        e = '{name, tmpl, fmt, cond, take, cls, aluop, cmpop, mtype, is_rem};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add("add",    32'h00000033, fmt_none, OPEN, 1, cls_alu, alu_add);
        add("sub",    32'h40000033, fmt_none, OPEN, 1, cls_alu, alu_sub);
        add("sll",    32'h00001033, fmt_none, OPEN, 1, cls_alu, alu_sll);
        add("slt",    32'h00002033, fmt_none, OPEN, 1, cls_alu, alu_slt);
        add("sltu",   32'h00003033, fmt_none, OPEN, 1, cls_alu, alu_sltu);
        add("xor",    32'h00004033, fmt_none, OPEN, 1, cls_alu, alu_xor);
        add("srl",    32'h00005033, fmt_none, OPEN, 1, cls_alu, alu_srl);
        add("sra",    32'h40005033, fmt_none, OPEN, 1, cls_alu, alu_sra);
        add("or",     32'h00006033, fmt_none, OPEN, 1, cls_alu, alu_or);
        add("and",    32'h00007033, fmt_none, OPEN, 1, cls_alu, alu_and);
        add("addi",   32'h00000013, fmt_i, OPEN, 1, cls_alu, alu_add);
        add("slti",   32'h00002013, fmt_i, OPEN, 1, cls_alu, alu_slt);
        add("sltiu",  32'h00003013, fmt_i, OPEN, 1, cls_alu, alu_sltu);
        add("xori",   32'h00004013, fmt_i, OPEN, 1, cls_alu, alu_xor);
        add("ori",    32'h00006013, fmt_i, OPEN, 1, cls_alu, alu_or);
        add("andi",   32'h00007013, fmt_i, OPEN, 1, cls_alu, alu_and);
        add("slli",   32'h00001013, fmt_i, OPEN, 1, cls_alu, alu_sll);
        add("srli",   32'h00005013, fmt_i, OPEN, 1, cls_alu, alu_srl);
        add("srai",   32'h40005013, fmt_i, OPEN, 1, cls_alu, alu_sra);
        add("lui",    32'h00000037, fmt_u, OPEN, 1, cls_alu, alu_lui);
        add("auipc",  32'h00000017, fmt_u, OPEN, 1, cls_alu, alu_auipc);
        add("mul",    32'h02000033, fmt_none, OPEN, 1, cls_mult, alu_mult, eq, 2'd0);
        add("mulh",   32'h02001033, fmt_none, OPEN, 1, cls_mult, alu_mult, eq, 2'd1);
        add("mulhsu", 32'h02002033, fmt_none, OPEN, 1, cls_mult, alu_mult, eq, 2'd2);
        add("mulhu",  32'h02003033, fmt_none, OPEN, 1, cls_mult, alu_mult, eq, 2'd3);
        add("div",    32'h02004033, fmt_none, OPEN, 1, cls_mult, alu_div, eq, 2'd1);
        add("divu",   32'h02005033, fmt_none, OPEN, 1, cls_mult, alu_div, eq, 2'd3);
        add("rem",    32'h02006033, fmt_none, OPEN, 1, cls_mult, alu_div, eq, 2'd1, 1);
        add("remu",   32'h02007033, fmt_none, OPEN, 1, cls_mult, alu_div, eq, 2'd3, 1);
        add("lw",     32'h00002003, fmt_i, OPEN, 1, cls_mem, alu_add);
        add("lbu",    32'h00004003, fmt_i, OPEN, 1, cls_mem, alu_add);
        add("sw",     32'h00002023, fmt_s, OPEN, 1, cls_mem, alu_add);
        add("sb",     32'h00000023, fmt_s, OPEN, 1, cls_mem, alu_add);
        add("jal",    32'h0000006f, fmt_j, OPEN, 1, cls_branch, alu_jal);
        add("jalr",   32'h00000067, fmt_i, OPEN, 1, cls_branch, alu_jalr);
        add("beq",    32'h00000063, fmt_b, OPEN, 1, cls_branch, alu_branch, eq);
        add("bne",    32'h00001063, fmt_b, OPEN, 1, cls_branch, alu_branch, ne);
        add("blt",    32'h00004063, fmt_b, OPEN, 1, cls_branch, alu_branch, lt);
        add("bge",    32'h00005063, fmt_b, OPEN, 1, cls_branch, alu_branch, ge);
        add("bltu",   32'h00006063, fmt_b, OPEN, 1, cls_branch, alu_branch, ltu);
        add("bgeu",   32'h00007063, fmt_b, OPEN, 1, cls_branch, alu_branch, geu);
        // Back-pressure and renaming corners
        add("add_rs_shut",  32'h00000033, fmt_none, OPEN ^ NO_RS, 0, cls_alu, alu_add);
        add("mul_shut",     32'h02000033, fmt_none, OPEN ^ NO_MULT, 0, cls_mult, alu_mult);
        add("lw_lsq_full",  32'h00002003, fmt_i, OPEN ^ LSQ_BUSY, 0, cls_mem, alu_add);
        add("beq_lsq_full", 32'h00000063, fmt_b, OPEN ^ LSQ_BUSY, 0, cls_branch, alu_branch);
        add("add_rob_full", 32'h00000033, fmt_none, OPEN ^ ROB_BUSY, 0, cls_alu, alu_add);
        add("add_fl_empty", 32'h00000033, fmt_none, OPEN ^ FL_DRY, 0, cls_alu, alu_add);
        add("sw_fl_empty",  32'h00002023, fmt_s, OPEN ^ FL_DRY, 1, cls_mem, alu_add);
        add("bne_fl_empty", 32'h00001063, fmt_b, OPEN ^ FL_DRY, 1, cls_branch, alu_branch, ne);
        add("add_x0_fl",    32'h00000033, fmt_none, OPEN ^ FL_DRY ^ RD_X0, 1, cls_alu, alu_add);
        add("addi_x0",      32'h00000013, fmt_i, OPEN ^ RD_X0, 1, cls_alu, alu_add);
        // Discarded instructions
        add("opcode_0b",    32'h0000000b, fmt_none, OPEN, 1, cls_illegal, alu_add);
        add("br_f3_010",    32'h00002063, fmt_none, OPEN, 1, cls_illegal, alu_add);
        add("br_f3_011",    32'h00003063, fmt_none, OPEN, 1, cls_illegal, alu_add);
        add("bad_rob_full", 32'h0000000b, fmt_none, OPEN ^ ROB_BUSY, 0, cls_illegal, alu_add);
    endtask

    task automatic drive_idle();
        iq_empty       = 1'b1;
        rs_open        = 1'b1;
        mult_rs_open   = 1'b1;
        lsq_full       = 1'b0;
        rob_full       = 1'b0;
        freelist_empty = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] mask;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [5:0]  pdv;
        logic [4:0]  rob;
        logic        rs1_used;
        logic        rs2_used;
        logic        wr;
        logic        exp_fl;
        logic [3:0]  exp_str;
        int          cycles;
        int          err_before;

        err_before = errors;
        mask = 32'h0000007f;
        if (e.fmt != fmt_u && e.fmt != fmt_j)
            mask |= 32'h00007000;   // funct3
        if (e.fmt == fmt_none || (e.tmpl[6:0] == OP_IMM && e.tmpl[13:12] == 2'b01))
            mask |= 32'hfe000000;   // funct7, also on immediate shifts
        if (e.cond[5])
            mask |= 32'h00000f80;
        inst = (e.tmpl & mask) | (rand_bits(32) & ~mask);

        rs1_used = e.cls != cls_illegal && e.fmt inside {fmt_none, fmt_i, fmt_s, fmt_b};
        rs2_used = e.cls != cls_illegal && e.fmt inside {fmt_none, fmt_s, fmt_b};
        wr       = e.cls != cls_illegal && e.fmt inside {fmt_none, fmt_i, fmt_u, fmt_j};
        if (wr && !e.cond[5] && inst[11:7] == 5'd0)
            inst[7] = 1'b1;   // Keep a writer off x0 unless asked
        pc      = rand_bits(30) << 2;
        pdv     = 6'(rand_bits(6));
        rob     = 5'(rand_bits(5));
        exp_fl  = e.take && wr && inst[11:7] != 5'd0;
        exp_str = e.take ? class_strobes(e.cls) : 4'b0000;

        @(negedge clk);
        iq_empty  = 1'b0;
        iq_inst   = inst;
        iq_pc     = pc;
        pd        = pdv;
        rob_index = rob;
        {rs_open, mult_rs_open, lsq_full, rob_full, freelist_empty} = e.cond[4:0];
        #2;
        check("iq_dequeue", iq_dequeue, e.take);
        check("freelist_dequeue", freelist_dequeue, exp_fl);

        @(negedge clk);
        drive_idle();
        cycles = 0;
        if (exp_str != 4'b0000) begin
            while (strobes == 4'b0000 && cycles < STROBE_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            assert (cycles < STROBE_TIMEOUT) else begin
                $display("Timed out waiting for the dispatch strobe of %s", e.name);
                errors++;
            end
            assert (cycles == 0 || cycles == STROBE_TIMEOUT) else begin
                $display("Dispatch strobe of %s came later than one cycle", e.name);
                errors++;
            end
        end
        check("dispatch strobes", strobes, exp_str);

        if (exp_str != 4'b0000) begin
            check("out_pc", out_pc, pc);
            check("out_imm", out_imm, expect_imm(e.fmt, inst));
            check("out_rd", out_rd, wr ? inst[11:7] : 5'd0);
            check("out_rs1", out_rs1, rs1_used ? inst[19:15] : 5'd0);
            check("out_rs2", out_rs2, rs2_used ? inst[24:20] : 5'd0);
            check("out_pd", out_pd, (wr && inst[11:7] != 5'd0) ? pdv : 6'd0);
            check("out_rob_entry", out_rob_entry, rob);
            check("out_aluop", out_aluop, e.aluop);
            check("out_cmpop", out_cmpop, e.cmpop);
            check("out_mult_type", out_mult_type, e.mtype);
            check("out_is_rem", out_is_rem, e.is_rem);
            check("out_use_imm", out_use_imm, e.fmt inside {fmt_i, fmt_s, fmt_u, fmt_j});
            check("out_is_load", out_is_load, inst[6:0] == OP_LOAD);
            check("out_is_store", out_is_store, inst[6:0] == OP_STORE);
            check("out_funct3", out_funct3, inst[14:12]);
        end
        $display("%-14s inst %h  %s", e.name, inst, (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int err_before;

        clk       = 1'b0;
        rst       = 1'b1;
        iq_inst   = 32'h000000b3;   // add x1, x0, x0 waiting during reset
        iq_pc     = '0;
        pd        = '0;
        rob_index = '0;
        drive_idle();
        iq_empty  = 1'b0;
        errors    = 0;
        lfsr      = SEED;
        build_table();

        // No dequeue while reset holds, even with a valid head entry
        err_before = errors;
        repeat (8) begin
            @(negedge clk);
            check("iq_dequeue", iq_dequeue, 1'b0);
        end
        rst = 1'b0;
        drive_idle();
        #2;
        check("iq_dequeue", iq_dequeue, 1'b0);
        check("dispatch strobes", strobes, 4'b0000);
        $display("%-14s %s", "reset_idle", (errors == err_before) ? "ok" : "FAILED");

        foreach (table_q[i])
            run_entry(table_q[i]);

        errors += u_dut.u_dispatch_assert.fail_count;
        $display("%0d tests run, %0d errors", table_q.size() + 1, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
verilog/rename_pkg.sv
verilog/decode_if.sv
verilog/imm_gen.sv
verilog/op_decode.sv
verilog/rename_dispatch.sv
verilog/decode_rename.sv
tb/decode_rename_assert.sv
tb/tb_decode_rename.sv

/* Bender.yml */
package:
  name: decode_rename

sources:
  - verilog/rename_pkg.sv
  - verilog/decode_if.sv
  - verilog/imm_gen.sv
  - verilog/op_decode.sv
  - verilog/rename_dispatch.sv
  - verilog/decode_rename.sv
  - target: test
    files:
      - tb/decode_rename_assert.sv
      - tb/tb_decode_rename.sv
